// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= tb_alc
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

lint:
	$(VERILATOR) --lint-only --timing --assert -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== filelist.f ====
rtl/alc_bus_pkg.sv
rtl/alc_adc_pkg.sv
rtl/alc_reg_if.sv
rtl/alc_sample_if.sv
rtl/alc_lb_port.sv
rtl/alc_adc_sequencer.sv
rtl/alc_limit_checker.sv
rtl/alc_history_buffer.sv
rtl/alc_top.sv
test/alc_asserts.sv
test/tb_alc.sv

// ==== rtl/alc_adc_pkg.sv ====
package alc_adc_pkg;

  typedef logic [11:0] sample_t;
  typedef logic [4:0]  channel_t;

  // Bit 5 set means no fault, low bits hold the channel.
  typedef logic [5:0] fault_code_t;

  localparam fault_code_t NO_FAULT = 6'b100000;

  // Request, wait for the strobe, then one settle cycle.
  typedef enum logic [1:0] {
    SEQ_REQUEST,
    SEQ_WAIT,
    SEQ_SETTLE
  } seq_state_t;

endpackage

// ==== rtl/alc_adc_sequencer.sv ====
module alc_adc_sequencer import alc_adc_pkg::*; #(
  parameter int NUM_CHANNELS = 32
) (
  input  logic           lb_clk,
  input  logic           hard_reset,
  input  logic           soft_reset,
  input  logic           adc_strb,
  input  sample_t        adc_result,
  output logic           adc_rd,
  output channel_t       adc_channel,
  alc_sample_if.source   samples
);

  localparam channel_t LAST_CHANNEL = channel_t'(NUM_CHANNELS - 1);

  seq_state_t state;
  channel_t   next_channel;

  assign next_channel = (adc_channel == LAST_CHANNEL) ? '0 : adc_channel + 1'b1;

  always_ff @(posedge lb_clk) begin
    if (hard_reset || soft_reset) begin
      state         <= SEQ_REQUEST;
      adc_rd        <= 1'b0;
      adc_channel   <= '1; // First request goes to channel 0.
      samples.valid <= 1'b0;
    end else begin
      samples.valid <= 1'b0;
      case (state)
        SEQ_REQUEST: begin
          if (!adc_strb) begin // Wait until the previous strobe is gone.
            adc_rd      <= 1'b1;
            adc_channel <= next_channel;
            state       <= SEQ_WAIT;
          end
        end
        SEQ_WAIT: begin
          if (adc_strb) begin
            adc_rd        <= 1'b0;
            samples.valid <= 1'b1;
            state         <= SEQ_SETTLE;
          end
        end
        default: state <= SEQ_REQUEST;
      endcase
    end
  end

  // Sample payload, qualified by valid.
  always_ff @(posedge lb_clk) begin
    if (state == SEQ_WAIT && adc_strb) begin
      samples.channel    <= adc_channel;
      samples.value      <= adc_result;
      samples.frame_last <= (adc_channel == LAST_CHANNEL);
    end
  end

endmodule

// ==== rtl/alc_bus_pkg.sv ====
package alc_bus_pkg;

  typedef logic [15:0] lb_word_t;

  // Word offset inside a register region.
  typedef logic [5:0] reg_index_t;

  // Hard limits, high at 2*ch and low at 2*ch+1.
  localparam lb_word_t ALC_HARD_A  = 16'h0400;
  localparam lb_word_t ALC_SOFT_A  = 16'h0440; // Same layout as the hard limits.
  localparam lb_word_t ALC_VALUE_A = 16'h0480; // Latest value per channel.
  localparam lb_word_t ALC_FAULT_A = 16'h04A0; // Hard fault, then soft fault.
  localparam lb_word_t ALC_RBUFF_A = 16'h04A2; // Ring buffer control and data.
  localparam lb_word_t ALC_END_A   = 16'h04A3;

  localparam lb_word_t RB_DONE_WORD  = 16'h4000; // Buffer exhausted.
  localparam lb_word_t RB_ERROR_WORD = 16'h8000; // Read while not frozen.

  typedef enum logic [2:0] {
    REG_HARD,
    REG_SOFT,
    REG_VALUE,
    REG_FAULT,
    REG_RBUFF
  } reg_region_t;

endpackage

// ==== rtl/alc_history_buffer.sv ====
module alc_history_buffer import alc_bus_pkg::*, alc_adc_pkg::*; #(
  parameter int RING_DEPTH = 256
) (
  input  logic       lb_clk,
  input  logic       hard_reset,
  input  logic       soft_reset,
  alc_reg_if.history reg_bus,
  alc_sample_if.sink samples
);

  localparam int AW = $clog2(RING_DEPTH);
  localparam logic [AW:0] FULL_COUNT = (AW+1)'(RING_DEPTH);

  sample_t ring [RING_DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] wr_ptr_next;
  logic [AW:0]   count;      // Stored entries, saturating.
  logic [AW:0]   count_next;
  logic [AW-1:0] rd_idx;
  logic [AW:0]   rd_left;
  logic          frozen;
  logic          write_en;
  logic          rb_access;

  assign write_en  = samples.valid && !frozen;
  assign rb_access = reg_bus.req && reg_bus.region == REG_RBUFF;

  // Pointer state after this cycle's sample, so a freeze sees it as newest.
  assign wr_ptr_next = write_en ? wr_ptr + 1'b1 : wr_ptr;
  assign count_next  = (write_en && count != FULL_COUNT) ? count + 1'b1 : count;

  always_comb begin
    if (!frozen) begin
      reg_bus.rbuff_rdata = RB_ERROR_WORD;
    end else if (rd_left == '0) begin
      reg_bus.rbuff_rdata = RB_DONE_WORD;
    end else begin
      reg_bus.rbuff_rdata = {4'b0, ring[rd_idx]};
    end
  end

  always_ff @(posedge lb_clk) begin
    if (write_en) begin
      ring[wr_ptr] <= samples.value;
    end
  end

  always_ff @(posedge lb_clk) begin
    if (hard_reset) begin
      wr_ptr  <= '0;
      count   <= '0;
      rd_idx  <= '0;
      rd_left <= '0;
    end else begin
      wr_ptr <= wr_ptr_next;
      count  <= count_next;
      if (rb_access && reg_bus.wr && reg_bus.wdata != '0) begin
        rd_idx  <= wr_ptr_next - 1'b1; // Newest entry.
        rd_left <= count_next;
      end else if (rb_access && !reg_bus.wr && frozen && rd_left != '0) begin
        rd_idx  <= rd_idx - 1'b1;      // Step back, wraps.
        rd_left <= rd_left - 1'b1;
      end
    end
  end

  always_ff @(posedge lb_clk) begin
    if (hard_reset || soft_reset) begin
      frozen <= 1'b0;
    end else if (rb_access && reg_bus.wr) begin
      frozen <= (reg_bus.wdata != '0);
    end
  end

endmodule

// ==== rtl/alc_lb_port.sv ====
module alc_lb_port import alc_bus_pkg::*; (
  input  logic     lb_clk,
  input  logic     hard_reset,
  input  logic     soft_reset,
  input  lb_word_t lb_addr,
  input  lb_word_t lb_data_in,
  input  logic     lb_rd,
  input  logic     lb_wr,
  output lb_word_t lb_data_out,
  output logic     lb_strb,
  alc_reg_if.port  reg_bus
);

  logic        in_region;
  reg_region_t region;
  lb_word_t    base;
  lb_word_t    offset;
  lb_word_t    rdata_sel;

  assign in_region = (lb_addr >= ALC_HARD_A) && (lb_addr < ALC_END_A);

  always_comb begin
    if (lb_addr < ALC_SOFT_A) begin
      region = REG_HARD;
      base   = ALC_HARD_A;
    end else if (lb_addr < ALC_VALUE_A) begin
      region = REG_SOFT;
      base   = ALC_SOFT_A;
    end else if (lb_addr < ALC_FAULT_A) begin
      region = REG_VALUE;
      base   = ALC_VALUE_A;
    end else if (lb_addr < ALC_RBUFF_A) begin
      region = REG_FAULT;
      base   = ALC_FAULT_A;
    end else begin
      region = REG_RBUFF;
      base   = ALC_RBUFF_A;
    end
  end

  assign offset = lb_addr - base;

  assign reg_bus.req    = (lb_rd | lb_wr) & in_region;
  assign reg_bus.wr     = lb_wr;
  assign reg_bus.region = region;
  assign reg_bus.index  = offset[5:0];
  assign reg_bus.wdata  = lb_data_in;

  always_comb begin
    case (region)
      REG_HARD:  rdata_sel = reg_bus.hard_rdata;
      REG_SOFT:  rdata_sel = reg_bus.soft_rdata;
      REG_VALUE: rdata_sel = reg_bus.value_rdata;
      REG_FAULT: rdata_sel = reg_bus.fault_rdata;
      default:   rdata_sel = reg_bus.rbuff_rdata;
    endcase
  end

  // Every access completes in one cycle; idle cycles drive zero for the OR bus.
  always_ff @(posedge lb_clk) begin
    if (hard_reset || soft_reset) begin
      lb_strb     <= 1'b0;
      lb_data_out <= '0;
    end else begin
      lb_strb     <= reg_bus.req;
      lb_data_out <= (reg_bus.req && !lb_wr) ? rdata_sel : '0;
    end
  end

endmodule

// ==== rtl/alc_limit_checker.sv ====
module alc_limit_checker import alc_bus_pkg::*, alc_adc_pkg::*; #(
  parameter int          NUM_CHANNELS   = 32,
  parameter logic [31:0] ESSENTIAL_MASK = 32'h0000_8012
) (
  input  logic       lb_clk,
  input  logic       hard_reset,
  input  logic       soft_reset,
  input  logic       no_power,
  output logic       irq,
  output logic       power_down,
  alc_reg_if.limits  reg_bus,
  alc_sample_if.sink samples
);

  localparam int NUM_LIMITS = 2 * NUM_CHANNELS;
  localparam int CW         = $clog2(NUM_CHANNELS);
  localparam int LW         = CW + 1;

  sample_t hard_level [NUM_LIMITS];
  sample_t soft_level [NUM_LIMITS];
  sample_t adc_values [NUM_CHANNELS];

  logic [NUM_LIMITS-1:0] hard_set; // Limit written since reset.
  logic [NUM_LIMITS-1:0] soft_set;

  fault_code_t fault_hard;
  fault_code_t fault_soft;

  logic          lim_in_range;
  logic          val_in_range;
  logic [LW-1:0] lim_idx;
  logic [CW-1:0] ch_idx;
  logic [LW-1:0] hi_idx;
  logic [LW-1:0] lo_idx;
  logic          lim_wr;
  logic          hard_hit;
  logic          soft_hit;
  logic          allowed;

  assign lim_in_range = (reg_bus.index < NUM_LIMITS);
  assign val_in_range = (reg_bus.index < NUM_CHANNELS);
  assign lim_idx      = reg_bus.index[LW-1:0];
  assign lim_wr       = reg_bus.req && reg_bus.wr && lim_in_range;

  assign reg_bus.hard_rdata  = lim_in_range ? {4'b0, hard_level[lim_idx]} : '0;
  assign reg_bus.soft_rdata  = lim_in_range ? {4'b0, soft_level[lim_idx]} : '0;
  assign reg_bus.value_rdata = val_in_range ? {4'b0, adc_values[lim_idx[CW-1:0]]} : '0;
  assign reg_bus.fault_rdata = reg_bus.index[0] ? {10'b0, fault_soft} : {10'b0, fault_hard};

  assign ch_idx = samples.channel[CW-1:0];
  assign hi_idx = {ch_idx, 1'b0};
  assign lo_idx = {ch_idx, 1'b1};

  assign hard_hit = (hard_set[hi_idx] && samples.value > hard_level[hi_idx]) ||
                    (hard_set[lo_idx] && samples.value < hard_level[lo_idx]);
  assign soft_hit = (soft_set[hi_idx] && samples.value > soft_level[hi_idx]) ||
                    (soft_set[lo_idx] && samples.value < soft_level[lo_idx]);

  // Only essential channels may fault while running without power.
  assign allowed = !no_power || ESSENTIAL_MASK[samples.channel];

  always_ff @(posedge lb_clk) begin
    if (lim_wr && reg_bus.region == REG_HARD) begin
      hard_level[lim_idx] <= reg_bus.wdata[11:0];
    end
    if (lim_wr && reg_bus.region == REG_SOFT) begin
      soft_level[lim_idx] <= reg_bus.wdata[11:0];
    end
    if (samples.valid) begin
      adc_values[ch_idx] <= samples.value;
    end
  end

  always_ff @(posedge lb_clk) begin
    if (hard_reset || soft_reset) begin
      hard_set   <= '0;
      soft_set   <= '0;
      irq        <= 1'b0;
      power_down <= 1'b0;
    end else begin
      if (lim_wr && reg_bus.region == REG_HARD) hard_set[lim_idx] <= 1'b1;
      if (lim_wr && reg_bus.region == REG_SOFT) soft_set[lim_idx] <= 1'b1;
      irq <= samples.valid && allowed && !hard_hit && soft_hit; // Single-cycle pulse.
      if (samples.valid && allowed && hard_hit) begin
        power_down <= 1'b1; // Sticky until reset.
      end
    end
  end

  // Fault codes survive a soft reset.
  always_ff @(posedge lb_clk) begin
    if (hard_reset) begin
      fault_hard <= NO_FAULT;
      fault_soft <= NO_FAULT;
    end else if (samples.valid && allowed) begin
      if (hard_hit) begin
        fault_hard <= {1'b0, samples.channel};
      end else if (soft_hit) begin
        fault_soft <= {1'b0, samples.channel};
      end
    end
  end

endmodule

// ==== rtl/alc_reg_if.sv ====
interface alc_reg_if import alc_bus_pkg::*; ();

  logic        req;    // In-region access, this cycle only.
  logic        wr;
  reg_region_t region;
  reg_index_t  index;
  lb_word_t    wdata;

  // Read data for the current request, valid in the request cycle.
  lb_word_t    hard_rdata;
  lb_word_t    soft_rdata;
  lb_word_t    value_rdata;
  lb_word_t    fault_rdata;
  lb_word_t    rbuff_rdata;

  modport port (
    output req, wr, region, index, wdata,
    input  hard_rdata, soft_rdata, value_rdata, fault_rdata, rbuff_rdata
  );

  modport limits (
    input  req, wr, region, index, wdata,
    output hard_rdata, soft_rdata, value_rdata, fault_rdata
  );

  modport history (
    input  req, wr, region, wdata,
    output rbuff_rdata
  );

endinterface

// ==== rtl/alc_sample_if.sv ====
interface alc_sample_if import alc_adc_pkg::*; ();

  logic     valid;      // One cycle per conversion.
  channel_t channel;
  sample_t  value;
  logic     frame_last; // Last channel of the scan.

  modport source (
    output valid, channel, value, frame_last
  );

  modport sink (
    input valid, channel, value, frame_last
  );

endinterface

// ==== rtl/alc_top.sv ====
module alc_top import alc_bus_pkg::*, alc_adc_pkg::*; #(
  parameter int          NUM_CHANNELS   = 32,
  parameter int          RING_DEPTH     = 256,
  parameter logic [31:0] ESSENTIAL_MASK = 32'h0000_8012 // Channels 1, 4 and 15.
) (
  input  logic     lb_clk,
  input  logic     hard_reset,
  input  logic     soft_reset,
  input  lb_word_t lb_addr,
  input  lb_word_t lb_data_in,
  input  logic     lb_rd,
  input  logic     lb_wr,
  output lb_word_t lb_data_out,
  output logic     lb_strb,
  output logic     adc_rd,
  output channel_t adc_channel,
  input  sample_t  adc_result,
  input  logic     adc_strb,
  output logic     irq,
  output logic     power_down,
  input  logic     no_power
);

  alc_reg_if    reg_bus ();
  alc_sample_if samples ();

  alc_lb_port u_lb_port (
    .lb_clk      (lb_clk),
    .hard_reset  (hard_reset),
    .soft_reset  (soft_reset),
    .lb_addr     (lb_addr),
    .lb_data_in  (lb_data_in),
    .lb_rd       (lb_rd),
    .lb_wr       (lb_wr),
    .lb_data_out (lb_data_out),
    .lb_strb     (lb_strb),
    .reg_bus     (reg_bus.port)
  );

  alc_adc_sequencer #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) u_adc_sequencer (
    .lb_clk      (lb_clk),
    .hard_reset  (hard_reset),
    .soft_reset  (soft_reset),
    .adc_strb    (adc_strb),
    .adc_result  (adc_result),
    .adc_rd      (adc_rd),
    .adc_channel (adc_channel),
    .samples     (samples.source)
  );

  alc_limit_checker #(
    .NUM_CHANNELS   (NUM_CHANNELS),
    .ESSENTIAL_MASK (ESSENTIAL_MASK)
  ) u_limit_checker (
    .lb_clk     (lb_clk),
    .hard_reset (hard_reset),
    .soft_reset (soft_reset),
    .no_power   (no_power),
    .irq        (irq),
    .power_down (power_down),
    .reg_bus    (reg_bus.limits),
    .samples    (samples.sink)
  );

  alc_history_buffer #(
    .RING_DEPTH (RING_DEPTH)
  ) u_history_buffer (
    .lb_clk     (lb_clk),
    .hard_reset (hard_reset),
    .soft_reset (soft_reset),
    .reg_bus    (reg_bus.history),
    .samples    (samples.sink)
  );

endmodule

// ==== test/alc_asserts.sv ====
module alc_asserts import alc_bus_pkg::*; (
  input logic     lb_clk,
  input logic     hard_reset,
  input logic     soft_reset,
  input lb_word_t lb_addr,
  input logic     lb_rd,
  input logic     lb_wr,
  input lb_word_t lb_data_out,
  input logic     lb_strb,
  input logic     adc_rd,
  input logic     adc_strb,
  input logic     irq,
  input logic     power_down
);

  int   fail_count = 0;
  logic rst;
  logic bus_req;

  assign rst     = hard_reset || soft_reset;
  assign bus_req = (lb_rd || lb_wr) && (lb_addr >= ALC_HARD_A) && (lb_addr < ALC_END_A);

  strb_after_req: assert property (@(posedge lb_clk) disable iff (rst) bus_req |=> lb_strb)
    else begin
      $error("lb_strb missing one cycle after a bus request");
      fail_count++;
    end

  strb_only_after_req: assert property (@(posedge lb_clk) disable iff (rst) !bus_req |=> !lb_strb)
    else begin
      $error("lb_strb high without a request in the cycle before");
      fail_count++;
    end

  data_idle_zero: assert property (@(posedge lb_clk) disable iff (rst)
      !lb_strb |-> lb_data_out == '0)
    else begin
      $error("lb_data_out is not zero while lb_strb is low");
      fail_count++;
    end

  irq_single: assert property (@(posedge lb_clk) disable iff (rst) irq |=> !irq)
    else begin
      $error("irq stayed high for two cycles");
      fail_count++;
    end

  // A reset in the previous cycle may also drop the request.
  rd_falls_on_strb: assert property (@(posedge lb_clk) disable iff (rst)
      $fell(adc_rd) |-> $past(adc_strb) || $past(rst))
    else begin
      $error("adc_rd fell without adc_strb");
      fail_count++;
    end

  power_down_sticky: assert property (@(posedge lb_clk) disable iff (rst)
      $fell(power_down) |-> $past(rst))
    else begin
      $error("power_down fell outside reset");
      fail_count++;
    end

endmodule

bind alc_top alc_asserts u_asserts (
  .lb_clk      (lb_clk),
  .hard_reset  (hard_reset),
  .soft_reset  (soft_reset),
  .lb_addr     (lb_addr),
  .lb_rd       (lb_rd),
  .lb_wr       (lb_wr),
  .lb_data_out (lb_data_out),
  .lb_strb     (lb_strb),
  .adc_rd      (adc_rd),
  .adc_strb    (adc_strb),
  .irq         (irq),
  .power_down  (power_down)
);

// ==== test/tb_alc.sv ====
module tb_alc
  import alc_bus_pkg::*;
();

  localparam int NCH             = 8;
  localparam int RING            = 16;
  localparam int CONV_CYCLES     = 8;  // Request, up to 4 wait cycles, settle, margin.
  localparam int PLANNED_SCANS   = 8;
  localparam int WATCHDOG_CYCLES = 10 * PLANNED_SCANS * NCH * CONV_CYCLES;

  logic        lb_clk = 1'b0;
  logic        hard_reset;
  logic        soft_reset;
  lb_word_t    lb_addr;
  lb_word_t    lb_data_in;
  lb_word_t    lb_data_out;
  logic        lb_rd;
  logic        lb_wr;
  logic        lb_strb;
  logic        adc_rd;
  logic        adc_strb;
  logic [4:0]  adc_channel;
  logic [11:0] adc_result;
  logic        irq;
  logic        power_down;
  logic        no_power;

  logic        adc_hold = 1'b0; // Model answers no new request while set.
  logic        adc_busy = 1'b0;
  logic [31:0] rng = 32'hb655_5092;
  int          seen [NCH];      // Conversions per channel.
  int          exp_ch = 0;      // Channel the next request must name.
  logic [11:0] last_val [NCH];
  logic [11:0] history [$];     // Every sample in arrival order.
  int          irq_count = 0;
  int          errors = 0;
  int          lim_ch [4] = '{0, 3, 6, 7};

  always #20 lb_clk = ~lb_clk;

  alc_top #(
    .NUM_CHANNELS (NCH),
    .RING_DEPTH   (RING)
  ) u_dut (
    .lb_clk      (lb_clk),
    .hard_reset  (hard_reset),
    .soft_reset  (soft_reset),
    .lb_addr     (lb_addr),
    .lb_data_in  (lb_data_in),
    .lb_rd       (lb_rd),
    .lb_wr       (lb_wr),
    .lb_data_out (lb_data_out),
    .lb_strb     (lb_strb),
    .adc_rd      (adc_rd),
    .adc_channel (adc_channel),
    .adc_result  (adc_result),
    .adc_strb    (adc_strb),
    .irq         (irq),
    .power_down  (power_down),
    .no_power    (no_power)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Each channel has its own 256-wide band. The scan number adds a small ramp.
  function automatic logic [11:0] sample_value(input int ch, input int scan);
    return 12'(ch * 256 + 16 + scan % 16);
  endfunction

  task automatic check(input string name, input lb_word_t expected, input lb_word_t actual);
    assert (actual === expected)
    else begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic await_strobe(input lb_word_t addr);
    int waited;
    waited = 0;
    while (lb_strb !== 1'b1 && waited < 4) begin
      @(posedge lb_clk);
      #2;
      waited++;
    end
    if (lb_strb !== 1'b1) begin
      $display("no bus strobe after access to address %h", addr);
      errors++;
    end
  endtask

  task automatic bus_write(input lb_word_t addr, input lb_word_t data);
    @(posedge lb_clk);
    #2;
    lb_addr    = addr;
    lb_data_in = data;
    lb_wr      = 1'b1;
    @(posedge lb_clk);
    #2;
    lb_wr = 1'b0;
    await_strobe(addr);
  endtask

  task automatic read_check(input string name, input lb_word_t addr, input lb_word_t expected);
    @(posedge lb_clk);
    #2;
    lb_addr = addr;
    lb_rd   = 1'b1;
    @(posedge lb_clk);
    #2;
    lb_rd = 1'b0;
    await_strobe(addr);
    check(name, expected, lb_data_out);
  endtask

  // Lets the conversion in flight finish and its sample reach every consumer.
  task automatic hold_adc();
    @(negedge lb_clk);
    adc_hold = 1'b1;
    @(negedge lb_clk);
    while (adc_busy) @(negedge lb_clk);
    repeat (4) @(posedge lb_clk);
    #2;
  endtask

  task automatic release_adc();
    @(negedge lb_clk);
    adc_hold = 1'b0;
  endtask

  task automatic wait_samples(input int ch, input int count);
    int target;
    target = seen[ch] + count;
    while (seen[ch] < target) @(negedge lb_clk);
  endtask

  always @(negedge lb_clk) begin
    if (irq === 1'b1) irq_count++;
  end

  // ADC model answers each request after 1 to 4 cycles.
  always begin : adc_model
    int          delay;
    int          ch;
    logic [11:0] value;
    @(posedge lb_clk);
    #2;
    if (adc_rd === 1'b1 && !adc_hold) begin
      adc_busy = 1'b1;
      rng      = xorshift(rng);
      delay    = int'(rng % 4) + 1;
      ch       = int'(adc_channel);
      check("adc channel", lb_word_t'(exp_ch), lb_word_t'(adc_channel));
      exp_ch   = (exp_ch + 1) % NCH; // Round robin over the channels.
      value    = sample_value(ch, seen[ch]);
      repeat (delay - 1) begin
        @(posedge lb_clk);
        #2;
      end
      adc_result = value;
      adc_strb   = 1'b1;
      @(posedge lb_clk);
      #2;
      adc_strb     = 1'b0;
      seen[ch]++;
      last_val[ch] = value;
      history.push_back(value);
      adc_busy     = 1'b0;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge lb_clk);
    $display("Run timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  initial begin : stimulus
    int base;
    hard_reset = 1'b1;
    soft_reset = 1'b0;
    lb_addr    = '0;
    lb_data_in = '0;
    lb_rd      = 1'b0;
    lb_wr      = 1'b0;
    adc_strb   = 1'b0;
    adc_result = '0;
    no_power   = 1'b0;
    repeat (4) @(posedge lb_clk);
    #2;
    hard_reset = 1'b0;

    // Two full scans with no limit written.
    wait_samples(NCH - 1, 2);
    hold_adc();
    for (int ch = 0; ch < NCH; ch++) begin
      read_check("latest value", ALC_VALUE_A + lb_word_t'(ch), {4'h0, last_val[ch]});
    end
    check("no limit irq", 16'h0, lb_word_t'(irq_count));
    read_check("no limit hard fault", ALC_FAULT_A, 16'h0020);
    read_check("no limit soft fault", ALC_FAULT_A + 16'd1, 16'h0020);

    // Upper bits are dropped. The limits sit outside every sample band.
    for (int i = 0; i < 4; i++) begin
      bus_write(ALC_HARD_A + lb_word_t'(2 * lim_ch[i]), 16'hAF00 + lb_word_t'(lim_ch[i]));
      bus_write(ALC_HARD_A + lb_word_t'(2 * lim_ch[i] + 1), 16'h5000 + lb_word_t'(lim_ch[i]));
      bus_write(ALC_SOFT_A + lb_word_t'(2 * lim_ch[i]), 16'h3E00 + lb_word_t'(lim_ch[i]));
      bus_write(ALC_SOFT_A + lb_word_t'(2 * lim_ch[i] + 1), 16'h9001 + lb_word_t'(lim_ch[i]));
    end
    for (int i = 0; i < 4; i++) begin
      read_check("hard high", ALC_HARD_A + lb_word_t'(2 * lim_ch[i]),
                 16'h0F00 + lb_word_t'(lim_ch[i]));
      read_check("hard low", ALC_HARD_A + lb_word_t'(2 * lim_ch[i] + 1), lb_word_t'(lim_ch[i]));
      read_check("soft high", ALC_SOFT_A + lb_word_t'(2 * lim_ch[i]),
                 16'h0E00 + lb_word_t'(lim_ch[i]));
      read_check("soft low", ALC_SOFT_A + lb_word_t'(2 * lim_ch[i] + 1),
                 16'h0001 + lb_word_t'(lim_ch[i]));
    end

    // Soft high limit of channel 2 below its band.
    irq_count = 0;
    base      = seen[2];
    bus_write(ALC_SOFT_A + 16'd4, 16'd500);
    release_adc();
    wait_samples(2, 1);
    hold_adc();
    check("soft irq count", lb_word_t'(seen[2] - base), lb_word_t'(irq_count));
    read_check("soft fault", ALC_FAULT_A + 16'd1, 16'h0002);
    read_check("hard fault after soft", ALC_FAULT_A, 16'h0020);

    no_power  = 1'b1;
    irq_count = 0;
    bus_write(ALC_HARD_A + 16'd4, 16'd500); // Channel 2 is not essential.
    release_adc();
    wait_samples(2, 1);
    hold_adc();
    check("no_power power_down", 16'h0, {15'h0, power_down});
    check("no_power irq", 16'h0, lb_word_t'(irq_count));
    read_check("no_power hard fault", ALC_FAULT_A, 16'h0020);
    bus_write(ALC_HARD_A + 16'd8, 16'd1000);
    release_adc();
    wait_samples(4, 1);
    hold_adc();
    check("essential power_down", 16'h1, {15'h0, power_down});
    read_check("essential hard fault", ALC_FAULT_A, 16'h0004);

    // History read back newest first.
    read_check("rbuff not frozen", ALC_RBUFF_A, RB_ERROR_WORD);
    bus_write(ALC_RBUFF_A, 16'h0001);
    for (int i = 0; i < RING; i++) begin
      read_check("rbuff entry", ALC_RBUFF_A, {4'h0, history[history.size() - 1 - i]});
    end
    read_check("rbuff done", ALC_RBUFF_A, RB_DONE_WORD);
    bus_write(ALC_RBUFF_A, 16'h0000);
    base = history.size();
    release_adc();
    while (history.size() < base + 3) @(negedge lb_clk);
    hold_adc();
    bus_write(ALC_RBUFF_A, 16'h0001);
    for (int i = 0; i < 3; i++) begin
      read_check("rbuff after unfreeze", ALC_RBUFF_A, {4'h0, history[history.size() - 1 - i]});
    end
    bus_write(ALC_RBUFF_A, 16'h0000);

    @(posedge lb_clk);
    #2;
    soft_reset = 1'b1;
    @(posedge lb_clk);
    #2;
    soft_reset = 1'b0;
    exp_ch     = 0; // The scan restarts at channel 0.
    check("soft reset power_down", 16'h0, {15'h0, power_down});
    no_power  = 1'b0;
    irq_count = 0;
    release_adc();
    wait_samples(NCH - 1, 1);
    hold_adc();
    check("soft reset irq", 16'h0, lb_word_t'(irq_count));
    check("soft reset power_down kept low", 16'h0, {15'h0, power_down});
    read_check("soft reset hard fault", ALC_FAULT_A, 16'h0004);
    read_check("soft reset soft fault", ALC_FAULT_A + 16'd1, 16'h0002);

    @(posedge lb_clk);
    #2;
    hard_reset = 1'b1;
    @(posedge lb_clk);
    #2;
    hard_reset = 1'b0;
    read_check("hard reset hard fault", ALC_FAULT_A, 16'h0020);
    read_check("hard reset soft fault", ALC_FAULT_A + 16'd1, 16'h0020);

    $display("Check summary: %0d value errors, %0d assertion failures",
             errors, u_dut.u_asserts.fail_count);
    if (errors == 0 && u_dut.u_asserts.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
